// ==== src/lsu_macros.svh ====
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// data and address width
`define XLEN 64

// memory depth in words
`define MEM_WORDS 256

// word index taken from addr[MEM_IDX_HI:MEM_IDX_LO]
`define MEM_IDX_LO 3
`define MEM_IDX_HI 10

`endif

// ==== src/axi_pkg.sv ====
`default_nettype none
`include "lsu_macros.svh"

package axi_pkg;

    // bus side payload types
    typedef logic [`XLEN-1:0]     addr_t;
    typedef logic [`XLEN-1:0]     data_t;
    typedef logic [`XLEN/8-1:0]   strb_t;   // one bit per byte lane
    typedef logic [1:0]           resp_t;

    // response encodings, as on B and R
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

// ==== src/lsu_pkg.sv ====
`default_nettype none
`include "lsu_macros.svh"

package lsu_pkg;

    // byte position inside one data word
    typedef logic [$clog2(`XLEN/8)-1:0] byte_off_t;

    // write side: address, data, then wait for B
    typedef enum logic [1:0] {
        W_IDLE,
        W_AW,
        W_DATA,
        W_RESP
    } wr_state_e;

    // read side: address, data, then hold result
    typedef enum logic [1:0] {
        R_IDLE,
        R_AR,
        R_DATA,
        R_DONE
    } rd_state_e;

endpackage

`default_nettype wire

// ==== src/axi_lite_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// single-beat AXI subset, no ids or burst fields
interface axi_lite_if;

    // write address
    logic           aw_valid;
    logic           aw_ready;
    axi_pkg::addr_t aw_addr;

    // write data
    logic           w_valid;
    logic           w_ready;
    axi_pkg::data_t w_data;
    axi_pkg::strb_t w_strb;
    logic           w_last;     // always set, single beat

    // write response
    logic           b_valid;
    logic           b_ready;
    axi_pkg::resp_t b_resp;

    // read address
    logic           ar_valid;
    logic           ar_ready;
    axi_pkg::addr_t ar_addr;

    // read data
    logic           r_valid;
    logic           r_ready;
    axi_pkg::data_t r_data;
    axi_pkg::resp_t r_resp;
    logic           r_last;

    modport master (
        output aw_valid, aw_addr, input  aw_ready,
        output w_valid, w_data, w_strb, w_last, input  w_ready,
        input  b_valid, b_resp, output b_ready,
        output ar_valid, ar_addr, input  ar_ready,
        input  r_valid, r_data, r_resp, r_last, output r_ready
    );

    modport slave (
        input  aw_valid, aw_addr, output aw_ready,
        input  w_valid, w_data, w_strb, w_last, output w_ready,
        output b_valid, b_resp, input  b_ready,
        input  ar_valid, ar_addr, output ar_ready,
        output r_valid, r_data, r_resp, r_last, input  r_ready
    );

endinterface

`default_nettype wire

// ==== src/axi_lsu_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lsu_macros.svh"

module axi_lsu_bridge (
    input  wire                 clock,
    input  wire                 reset,
    input  wire                 wr_valid_i,
    input  wire                 rd_valid_i,
    input  wire axi_pkg::addr_t addr_i,
    input  wire axi_pkg::data_t wr_data_i,
    input  wire axi_pkg::strb_t wr_mask_i,
    output logic                wr_ok_o,
    output logic                wr_err_o,
    output logic                rd_ready_o,
    output logic                rd_err_o,
    output axi_pkg::data_t      rd_data_o,
    axi_lite_if.master          bus
);

    lsu_pkg::wr_state_e wr_state, wr_state_nxt;
    lsu_pkg::rd_state_e rd_state, rd_state_nxt;

    axi_pkg::addr_t     addr_q;       // address of the last issued request
    logic               addr_match;
    lsu_pkg::byte_off_t byte_off;

    logic               wr_done_q;    // B seen in W_RESP
    logic               wr_err_q;
    logic               rd_err_q;
    axi_pkg::data_t     rd_data_q;

    assign addr_match = (addr_i == addr_q);
    assign byte_off   = addr_i[$bits(lsu_pkg::byte_off_t)-1:0];

    // write machine
    always_comb begin
        wr_state_nxt = wr_state;
        case (wr_state)
            lsu_pkg::W_IDLE: begin
                if (wr_valid_i) begin
                    wr_state_nxt = lsu_pkg::W_AW;
                end
            end
            lsu_pkg::W_AW: begin
                if (bus.aw_ready) begin
                    wr_state_nxt = lsu_pkg::W_DATA;
                end
            end
            lsu_pkg::W_DATA: begin
                if (bus.w_ready) begin
                    wr_state_nxt = lsu_pkg::W_RESP;
                end
            end
            lsu_pkg::W_RESP: begin
                // leave only once the response is in
                if (wr_done_q) begin
                    if (!wr_valid_i) begin
                        wr_state_nxt = lsu_pkg::W_IDLE;
                    end else if (!addr_match) begin
                        wr_state_nxt = lsu_pkg::W_AW;   // new request under the same valid
                    end
                end
            end
            default: wr_state_nxt = lsu_pkg::W_IDLE;
        endcase
    end

    // read machine
    always_comb begin
        rd_state_nxt = rd_state;
        case (rd_state)
            lsu_pkg::R_IDLE: begin
                if (rd_valid_i) begin
                    rd_state_nxt = lsu_pkg::R_AR;
                end
            end
            lsu_pkg::R_AR: begin
                if (bus.ar_ready) begin
                    rd_state_nxt = lsu_pkg::R_DATA;
                end
            end
            lsu_pkg::R_DATA: begin
                if (bus.r_valid) begin
                    rd_state_nxt = lsu_pkg::R_DONE;
                end
            end
            lsu_pkg::R_DONE: begin
                if (!rd_valid_i) begin
                    rd_state_nxt = lsu_pkg::R_IDLE;
                end else if (!addr_match) begin
                    rd_state_nxt = lsu_pkg::R_AR;
                end
            end
            default: rd_state_nxt = lsu_pkg::R_IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wr_state  <= lsu_pkg::W_IDLE;
            rd_state  <= lsu_pkg::R_IDLE;
            wr_done_q <= 1'b0;
        end else begin
            wr_state <= wr_state_nxt;
            rd_state <= rd_state_nxt;
            if (bus.b_valid && bus.b_ready) begin
                wr_done_q <= 1'b1;
            end else if (wr_state != lsu_pkg::W_RESP) begin
                wr_done_q <= 1'b0;
            end
        end
    end

    // payload captures
    always_ff @(posedge clock) begin
        if (wr_state == lsu_pkg::W_AW || rd_state == lsu_pkg::R_AR) begin
            addr_q <= addr_i;
        end
        if (bus.b_valid && bus.b_ready) begin
            wr_err_q <= (bus.b_resp == axi_pkg::RESP_SLVERR);
        end
        if (bus.r_valid && bus.r_ready) begin
            rd_data_q <= bus.r_data;
            rd_err_q  <= (bus.r_resp == axi_pkg::RESP_SLVERR);
        end
    end

    // bus side
    assign bus.aw_valid = (wr_state == lsu_pkg::W_AW);
    assign bus.aw_addr  = addr_i & ~axi_pkg::addr_t'((`XLEN / 8) - 1);   // word aligned
    assign bus.w_valid  = (wr_state == lsu_pkg::W_DATA);
    assign bus.w_data   = wr_data_i << {byte_off, 3'b000};   // move to its byte lanes
    assign bus.w_strb   = wr_mask_i << byte_off;
    assign bus.w_last   = (wr_state == lsu_pkg::W_DATA);
    assign bus.b_ready  = (wr_state == lsu_pkg::W_RESP) && !wr_done_q;
    assign bus.ar_valid = (rd_state == lsu_pkg::R_AR);
    assign bus.ar_addr  = addr_i;
    assign bus.r_ready  = (rd_state == lsu_pkg::R_DATA);

    // core side outputs only while the same request is still held
    assign wr_ok_o    = (wr_state == lsu_pkg::W_RESP) && wr_done_q && wr_valid_i && addr_match;
    assign wr_err_o   = wr_ok_o && wr_err_q;
    assign rd_ready_o = (rd_state == lsu_pkg::R_DONE) && rd_valid_i && addr_match;
    assign rd_err_o   = rd_ready_o && rd_err_q;
    assign rd_data_o  = rd_ready_o ? rd_data_q : '0;

    aw_valid_held: assert property (
        @(posedge clock) disable iff (!reset)
        bus.aw_valid && !bus.aw_ready |=> bus.aw_valid
    ) else $error("aw valid dropped before aw ready");

    aw_w_exclusive: assert property (
        @(posedge clock) disable iff (!reset)
        !(bus.aw_valid && bus.w_valid)
    ) else $error("aw valid and w valid high together");

    r_last_on_xfer: assert property (
        @(posedge clock) disable iff (!reset)
        bus.r_valid && bus.r_ready |-> bus.r_last
    ) else $error("r transfer without r last");

endmodule

`default_nettype wire

// ==== src/axi_sram_slave.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lsu_macros.svh"

module axi_sram_slave (
    input  wire        clock,
    input  wire        reset,
    axi_lite_if.slave  bus
);

    typedef logic [`MEM_IDX_HI-`MEM_IDX_LO:0] idx_t;

    axi_pkg::data_t mem [`MEM_WORDS];

    axi_pkg::addr_t aw_addr_q;
    logic           w_ready_q;     // aw accepted, waiting for w
    logic           b_valid_q;
    axi_pkg::resp_t b_resp_q;

    logic           r_valid_q;
    axi_pkg::data_t r_data_q;
    axi_pkg::resp_t r_resp_q;

    logic           aw_hs, w_hs, b_hs, ar_hs, r_hs;
    logic           wr_in_range, rd_in_range;
    idx_t           wr_idx, rd_idx;

    assign aw_hs = bus.aw_valid && bus.aw_ready;
    assign w_hs  = bus.w_valid && bus.w_ready;
    assign b_hs  = bus.b_valid && bus.b_ready;
    assign ar_hs = bus.ar_valid && bus.ar_ready;
    assign r_hs  = bus.r_valid && bus.r_ready;

    // anything above the index bits is outside the memory
    assign wr_in_range = (aw_addr_q[`XLEN-1:`MEM_IDX_HI+1] == '0);
    assign rd_in_range = (bus.ar_addr[`XLEN-1:`MEM_IDX_HI+1] == '0);
    assign wr_idx      = aw_addr_q[`MEM_IDX_HI:`MEM_IDX_LO];
    assign rd_idx      = bus.ar_addr[`MEM_IDX_HI:`MEM_IDX_LO];

    // handshake state for both sides
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            w_ready_q <= 1'b0;
            b_valid_q <= 1'b0;
            r_valid_q <= 1'b0;
        end else begin
            if (aw_hs) begin
                w_ready_q <= 1'b1;
            end else if (w_hs) begin
                w_ready_q <= 1'b0;
            end

            if (w_hs) begin
                b_valid_q <= 1'b1;
            end else if (b_hs) begin
                b_valid_q <= 1'b0;
            end

            if (ar_hs) begin
                r_valid_q <= 1'b1;
            end else if (r_hs) begin
                r_valid_q <= 1'b0;
            end
        end
    end

    // storage and payload
    always_ff @(posedge clock) begin
        if (aw_hs) begin
            aw_addr_q <= bus.aw_addr;
        end
        if (w_hs) begin
            b_resp_q <= wr_in_range ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
            if (wr_in_range) begin   // out of range writes are dropped
                for (int i = 0; i < `XLEN / 8; i++) begin
                    if (bus.w_strb[i]) begin
                        mem[wr_idx][i*8 +: 8] <= bus.w_data[i*8 +: 8];
                    end
                end
            end
        end
        if (ar_hs) begin
            r_data_q <= rd_in_range ? mem[rd_idx] : '0;
            r_resp_q <= rd_in_range ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
        end
    end

    assign bus.aw_ready = !w_ready_q && !b_valid_q;   // write side idle
    assign bus.w_ready  = w_ready_q;
    assign bus.b_valid  = b_valid_q;
    assign bus.b_resp   = b_resp_q;
    assign bus.ar_ready = !r_valid_q;
    assign bus.r_valid  = r_valid_q;
    assign bus.r_data   = r_data_q;
    assign bus.r_resp   = r_resp_q;
    assign bus.r_last   = r_valid_q;   // single beat

    w_last_on_xfer: assert property (
        @(posedge clock) disable iff (!reset)
        w_hs |-> bus.w_last
    ) else $error("w transfer without w last");

    b_valid_held: assert property (
        @(posedge clock) disable iff (!reset)
        bus.b_valid && !bus.b_ready |=> bus.b_valid
    ) else $error("b valid dropped before b ready");

endmodule

`default_nettype wire

// ==== src/lsu_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_mem_top (
    input  wire                 clock,
    input  wire                 reset,
    input  wire                 wr_valid_i,
    input  wire                 rd_valid_i,
    input  wire axi_pkg::addr_t addr_i,
    input  wire axi_pkg::data_t wr_data_i,
    input  wire axi_pkg::strb_t wr_mask_i,
    output logic                wr_ok_o,
    output logic                wr_err_o,
    output logic                rd_ready_o,
    output logic                rd_err_o,
    output axi_pkg::data_t      rd_data_o
);

    axi_lite_if bus ();

    // core requests to AXI
    axi_lsu_bridge u_bridge (
        .clock      (clock),
        .reset      (reset),
        .wr_valid_i (wr_valid_i),
        .rd_valid_i (rd_valid_i),
        .addr_i     (addr_i),
        .wr_data_i  (wr_data_i),
        .wr_mask_i  (wr_mask_i),
        .wr_ok_o    (wr_ok_o),
        .wr_err_o   (wr_err_o),
        .rd_ready_o (rd_ready_o),
        .rd_err_o   (rd_err_o),
        .rd_data_o  (rd_data_o),
        .bus        (bus.master)
    );

    axi_sram_slave u_sram (
        .clock (clock),
        .reset (reset),
        .bus   (bus.slave)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clock_o,
    output logic reset_o
);

    initial begin
        clock_o = 1'b0;
        forever #4 clock_o = ~clock_o;   // 8 ns period
    end

    // active low over the first two rising edges
    initial begin
        reset_o = 1'b0;
        repeat (2) @(posedge clock_o);
        reset_o <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_lsu_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lsu_macros.svh"

module tb_lsu_mem_top;

    localparam int N_RAND = 40;   // write then read pairs
    localparam int N_ERR  = 8;
    localparam int N_HOLD = 6;
    localparam int N_PAIR = 8;
    localparam int N_TXN  = `MEM_WORDS + 2 * N_RAND + 3 * N_ERR + 6 * N_HOLD + 2 * N_PAIR;
    localparam int TIMEOUT_CYCLES = 40 * N_TXN;

    logic           clock, reset;
    logic           wr_valid, rd_valid;
    axi_pkg::addr_t addr;
    axi_pkg::data_t wr_data, rd_data;
    axi_pkg::strb_t wr_mask;
    logic           wr_ok, wr_err, rd_ready, rd_err;

    logic           wr_start, rd_start;   // high in the first cycle of a request
    logic           exp_wr_err, exp_rd_err;
    axi_pkg::data_t exp_rd_data;
    logic [7:0]     ref_mem [`MEM_WORDS * 8];   // byte-wise copy of the memory
    int             cycle_cnt = 0;

    tb_clock_gen u_clock_gen (.clock_o(clock), .reset_o(reset));

    lsu_mem_top dut (
        .clock      (clock),
        .reset      (reset),
        .wr_valid_i (wr_valid),
        .rd_valid_i (rd_valid),
        .addr_i     (addr),
        .wr_data_i  (wr_data),
        .wr_mask_i  (wr_mask),
        .wr_ok_o    (wr_ok),
        .wr_err_o   (wr_err),
        .rd_ready_o (rd_ready),
        .rd_err_o   (rd_err),
        .rd_data_o  (rd_data)
    );

    task automatic report_error(input string msg);
        $display("ERR at %0d ns: %s", $time, msg);
        $display("RESULT: FAIL");
        $fatal(1, "check failed");
    endtask

    function automatic bit in_range(input axi_pkg::addr_t a);
        return a[`XLEN-1:`MEM_IDX_HI+1] == '0;
    endfunction

    function automatic axi_pkg::data_t ref_word(input axi_pkg::addr_t a);
        axi_pkg::data_t w;
        for (int i = 0; i < 8; i++) begin
            w[i*8 +: 8] = ref_mem[{a[`MEM_IDX_HI:`MEM_IDX_LO], 3'(i)}];
        end
        return w;
    endfunction

    // masked bytes land at lane i + offset and lanes past the word are lost
    task automatic apply_write(input axi_pkg::addr_t a, input axi_pkg::data_t d,
                               input axi_pkg::strb_t m);
        int off;
        off = int'(a[2:0]);
        if (in_range(a)) begin
            for (int i = 0; i < 8; i++) begin
                if (m[i] && (i + off) < 8) begin
                    ref_mem[{a[`MEM_IDX_HI:`MEM_IDX_LO], 3'(i + off)}] = d[i*8 +: 8];
                end
            end
        end
    endtask

    task automatic write_req(input axi_pkg::addr_t a, input axi_pkg::data_t d,
                             input axi_pkg::strb_t m, input bit hold);
        @(posedge clock);
        addr       <= a;
        wr_data    <= d;
        wr_mask    <= m;
        wr_valid   <= 1'b1;
        wr_start   <= 1'b1;
        exp_wr_err <= !in_range(a);
        @(posedge clock);
        wr_start <= 1'b0;
        while (!wr_ok) @(posedge clock);
        apply_write(a, d, m);
        if (!hold) wr_valid <= 1'b0;   // held valid keeps the bridge in its done state
    endtask

    task automatic read_req(input axi_pkg::addr_t a, input bit hold);
        @(posedge clock);
        addr        <= a;
        rd_valid    <= 1'b1;
        rd_start    <= 1'b1;
        exp_rd_err  <= !in_range(a);
        exp_rd_data <= ref_word(a);
        @(posedge clock);
        rd_start <= 1'b0;
        while (!rd_ready) @(posedge clock);
        if (!hold) rd_valid <= 1'b0;
    endtask

    always @(posedge clock) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles, a request never completed", cycle_cnt);
            $display("RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    wr_ok_on_time: assert property (@(posedge clock) disable iff (!reset)
        $past(wr_start, 4) |-> wr_ok
    ) else report_error("write not done 4 cycles after the request");

    wr_ok_not_early: assert property (@(posedge clock) disable iff (!reset)
        $rose(wr_ok) |-> $past(wr_start, 4)
    ) else report_error("wr_ok rose without a request 4 cycles earlier");

    wr_ok_low_on_new: assert property (@(posedge clock) disable iff (!reset)
        wr_start |-> !wr_ok
    ) else report_error("wr_ok high in the first cycle of a new request");

    wr_idle_low: assert property (@(posedge clock) disable iff (!reset)
        !wr_valid |-> !wr_ok && !wr_err
    ) else report_error("write outputs high with no write request");

    wr_err_match: assert property (@(posedge clock) disable iff (!reset)
        wr_ok |-> wr_err == exp_wr_err
    ) else report_error($sformatf("wr_err %0b, expected %0b",
                                  $sampled(wr_err), $sampled(exp_wr_err)));

    rd_ready_on_time: assert property (@(posedge clock) disable iff (!reset)
        $past(rd_start, 3) |-> rd_ready
    ) else report_error("read not done 3 cycles after the request");

    rd_ready_not_early: assert property (@(posedge clock) disable iff (!reset)
        $rose(rd_ready) |-> $past(rd_start, 3)
    ) else report_error("rd_ready rose without a request 3 cycles earlier");

    rd_ready_low_on_new: assert property (@(posedge clock) disable iff (!reset)
        rd_start |-> !rd_ready
    ) else report_error("rd_ready high in the first cycle of a new request");

    rd_idle_low: assert property (@(posedge clock) disable iff (!reset)
        !rd_valid |-> !rd_ready && !rd_err
    ) else report_error("read outputs high with no read request");

    rd_err_match: assert property (@(posedge clock) disable iff (!reset)
        rd_ready |-> rd_err == exp_rd_err
    ) else report_error($sformatf("rd_err %0b, expected %0b",
                                  $sampled(rd_err), $sampled(exp_rd_err)));

    rd_data_match: assert property (@(posedge clock) disable iff (!reset)
        rd_ready && !exp_rd_err |-> rd_data == exp_rd_data
    ) else report_error($sformatf("read data %h, expected %h",
                                  $sampled(rd_data), $sampled(exp_rd_data)));

    initial begin
        axi_pkg::addr_t a;
        axi_pkg::addr_t b;
        void'($urandom(60049));
        wr_valid <= 1'b0;
        rd_valid <= 1'b0;
        addr     <= '0;
        wr_data  <= '0;
        wr_mask  <= '0;
        wr_start <= 1'b0;
        rd_start <= 1'b0;
        exp_wr_err  <= 1'b0;
        exp_rd_err  <= 1'b0;
        exp_rd_data <= '0;
        @(posedge reset);
        repeat (4) @(posedge clock);   // idle cycles with the outputs low

        for (int w = 0; w < `MEM_WORDS; w++) begin   // fill every word
            write_req(axi_pkg::addr_t'(w * 8), {$urandom, $urandom}, 8'hff, 1'b0);
        end

        for (int n = 0; n < N_RAND; n++) begin
            a = axi_pkg::addr_t'($urandom % (`MEM_WORDS * 8));
            write_req(a, {$urandom, $urandom}, 8'($urandom), 1'b0);
            read_req({a[`XLEN-1:3], 3'($urandom)}, 1'b0);
        end

        // out of range access leaves the in-range alias untouched
        for (int n = 0; n < N_ERR; n++) begin
            a = axi_pkg::addr_t'($urandom % (`MEM_WORDS * 8));
            b = a | (64'd1 << (`MEM_IDX_HI + 1 + ($urandom % 53)));
            write_req(b, {$urandom, $urandom}, 8'hff, 1'b0);
            read_req(b, 1'b0);
            read_req(a, 1'b0);
        end

        // new address under a held valid
        for (int n = 0; n < N_HOLD; n++) begin
            a = axi_pkg::addr_t'($urandom % (`MEM_WORDS * 8));
            b = a ^ 64'h8;   // neighbour word
            write_req(a, {$urandom, $urandom}, 8'($urandom), 1'b1);
            write_req(b, {$urandom, $urandom}, 8'($urandom), 1'b0);
            read_req(a, 1'b1);
            read_req(b, 1'b0);
            // same address again once the valid has dropped
            write_req(b, {$urandom, $urandom}, 8'($urandom), 1'b0);
            read_req(b, 1'b0);
        end

        // one address port means the pair shares a word and rewrites what it holds
        for (int n = 0; n < N_PAIR; n++) begin
            a = axi_pkg::addr_t'($urandom % `MEM_WORDS) << 3;
            fork
                write_req(a, ref_word(a), 8'($urandom), 1'b0);
                read_req(a, 1'b0);
            join
        end

        repeat (6) @(posedge clock);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== lsu_mem.f ====
+incdir+src
src/axi_pkg.sv
src/lsu_pkg.sv
src/axi_lite_if.sv
src/axi_lsu_bridge.sv
src/axi_sram_slave.sv
src/lsu_mem_top.sv
testbench/tb_clock_gen.sv
testbench/tb_lsu_mem_top.sv

// ==== Makefile ====
TOP := tb_lsu_mem_top

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

obj_dir/V$(TOP): lsu_mem.f $(wildcard src/*.sv src/*.svh testbench/*.sv)
	verilator --binary --assert -j 0 --top-module $(TOP) -f lsu_mem.f

test: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir
